/* commit_top.f */
src/commit_pkg.sv
src/slot_if.sv
src/exec_commit_reg.sv
src/load_capture.sv
src/readdata_format.sv
src/slot_writeback.sv
src/redirect_unit.sv
src/commit_top.sv
tb/commit_checker.sv
tb/commit_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the commit stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module commit_tb -f commit_top.f -o commit_sim \
    > build.log 2>&1 \
    && ./obj_dir/commit_sim > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "simulation reported failure"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

/* src/commit_pkg.sv */
package commit_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  op_t;

    // issue width of the pipeline
    localparam int NUM_SLOTS = 2;

    // fall-through from the older slot skips the whole pair
    localparam word_t PAIR_BYTES = 32'd8;

    // committed operation codes
    localparam op_t OP_ALU = 4'd0;
    localparam op_t OP_LB  = 4'd1;
    localparam op_t OP_LBU = 4'd2;
    localparam op_t OP_LH  = 4'd3;
    localparam op_t OP_LHU = 4'd4;
    localparam op_t OP_LW  = 4'd5;
    localparam op_t OP_SB  = 4'd6;
    localparam op_t OP_SH  = 4'd7;
    localparam op_t OP_SW  = 4'd8;

    // packed slot fields from the msb down
    // valid, pc, op, destreg, regwrite, memtoreg, alu_result, mem_addr,
    // is_branch, is_jump, taken, pred_taken, target
    localparam int SLOT_BITS = 4 * $bits(word_t) + $bits(op_t) + $bits(reg_addr_t) + 7;

    typedef logic [SLOT_BITS-1:0] slot_bits_t;

    // everything but the valid bit
    typedef logic [SLOT_BITS-2:0] slot_payload_t;

endpackage

/* src/commit_top.sv */
`timescale 1ns/100ps

module commit_top
    import commit_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      stall,
    // older slot from execute
    input  logic      valid_1, regwrite_1, memtoreg_1,
    input  logic      is_branch_1, is_jump_1, taken_1, pred_taken_1,
    input  word_t     pc_1, alu_result_1, mem_addr_1, target_1,
    input  op_t       op_1,
    input  reg_addr_t destreg_1,
    // younger slot
    input  logic      valid_0, regwrite_0, memtoreg_0,
    input  logic      is_branch_0, is_jump_0, taken_0, pred_taken_0,
    input  word_t     pc_0, alu_result_0, mem_addr_0, target_0,
    input  op_t       op_0,
    input  reg_addr_t destreg_0,
    // data memory
    input  logic      dmem_en,
    input  word_t     dmem_rdata,
    input  logic      dmem_data_ok,
    // register writes and bypass
    output logic      wb_en_1, wb_en_0,
    output reg_addr_t wb_reg_1, wb_reg_0,
    output word_t     wb_data_1, wb_data_0,
    output logic      finish,
    // fetch and predictor
    output logic      redirect_valid,
    output word_t     redirect_pc,
    output logic      bpb_wen,
    output word_t     bpb_pc,
    output logic      bpb_taken,
    output word_t     bpb_target
);

    slot_bits_t in_1;
    slot_bits_t in_0;
    word_t      rdata;
    word_t      load_data;

    slot_if slot1 ();
    slot_if slot0 ();

    assign in_1 = {valid_1, pc_1, op_1, destreg_1, regwrite_1, memtoreg_1,
                   alu_result_1, mem_addr_1, is_branch_1, is_jump_1,
                   taken_1, pred_taken_1, target_1};
    assign in_0 = {valid_0, pc_0, op_0, destreg_0, regwrite_0, memtoreg_0,
                   alu_result_0, mem_addr_0, is_branch_0, is_jump_0,
                   taken_0, pred_taken_0, target_0};

    exec_commit_reg u_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall),
        .in_1  (in_1),
        .in_0  (in_0),
        .slot1 (slot1),
        .slot0 (slot0)
    );

    load_capture u_capture (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .dmem_en      (dmem_en),
        .dmem_data_ok (dmem_data_ok),
        .dmem_rdata   (dmem_rdata),
        .rdata        (rdata),
        .finish       (finish)
    );

    readdata_format u_format (
        .slot1     (slot1),
        .slot0     (slot0),
        .rdata     (rdata),
        .load_data (load_data)
    );

    slot_writeback u_wb1 (
        .slot      (slot1),
        .load_data (load_data),
        .finish    (finish),
        .wb_en     (wb_en_1),
        .wb_reg    (wb_reg_1),
        .wb_data   (wb_data_1)
    );

    slot_writeback u_wb0 (
        .slot      (slot0),
        .load_data (load_data),
        .finish    (finish),
        .wb_en     (wb_en_0),
        .wb_reg    (wb_reg_0),
        .wb_data   (wb_data_0)
    );

    redirect_unit u_redirect (
        .slot1          (slot1),
        .redirect_valid (redirect_valid),
        .bpb_wen        (bpb_wen),
        .bpb_taken      (bpb_taken),
        .redirect_pc    (redirect_pc),
        .bpb_pc         (bpb_pc),
        .bpb_target     (bpb_target)
    );

endmodule

/* src/exec_commit_reg.sv */
`timescale 1ns/100ps

module exec_commit_reg
    import commit_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       stall,
    input  slot_bits_t in_1,
    input  slot_bits_t in_0,
    slot_if.src        slot1,
    slot_if.src        slot0
);

    logic [NUM_SLOTS-1:0] valid_q;
    slot_payload_t        data_q [NUM_SLOTS];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            valid_q <= '0;
        end
        else if (!stall)
        begin
            valid_q <= {in_1[SLOT_BITS-1], in_0[SLOT_BITS-1]};
        end
    end

    // payload of both slots
    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            data_q[1] <= in_1[SLOT_BITS-2:0];
            data_q[0] <= in_0[SLOT_BITS-2:0];
        end
    end

    assign slot1.valid = valid_q[1];
    assign {slot1.pc, slot1.op, slot1.destreg, slot1.regwrite, slot1.memtoreg,
            slot1.alu_result, slot1.mem_addr, slot1.is_branch, slot1.is_jump,
            slot1.taken, slot1.pred_taken, slot1.target} = data_q[1];

    assign slot0.valid = valid_q[0];
    assign {slot0.pc, slot0.op, slot0.destreg, slot0.regwrite, slot0.memtoreg,
            slot0.alu_result, slot0.mem_addr, slot0.is_branch, slot0.is_jump,
            slot0.taken, slot0.pred_taken, slot0.target} = data_q[0];

endmodule

/* src/load_capture.sv */
`timescale 1ns/100ps

module load_capture
    import commit_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  stall,
    input  logic  dmem_en,
    input  logic  dmem_data_ok,
    input  word_t dmem_rdata,
    output word_t rdata,
    output logic  finish
);

    logic  ok_held;
    word_t rdata_held;

    // keep the first answer seen while the pair is stuck
    always_ff @(posedge clk)
    begin
        if (!rst_n || !stall)
        begin
            ok_held    <= 1'b0;
            rdata_held <= '0;
        end
        else if (dmem_data_ok && !ok_held)
        begin
            ok_held    <= 1'b1;
            rdata_held <= dmem_rdata;
        end
    end

    assign rdata  = dmem_data_ok ? dmem_rdata : rdata_held;
    assign finish = !dmem_en || dmem_data_ok || ok_held;

endmodule

/* src/readdata_format.sv */
`timescale 1ns/100ps

module readdata_format
    import commit_pkg::*;
(
    slot_if.dst   slot1,
    slot_if.dst   slot0,
    input  word_t rdata,
    output word_t load_data
);

    function automatic logic is_mem_op(input op_t op);
        case (op)
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: is_mem_op = 1'b1;
            OP_SB, OP_SH, OP_SW:                is_mem_op = 1'b1;
            OP_ALU:                             is_mem_op = 1'b0;
            default:                            is_mem_op = 1'b0;
        endcase
    endfunction

    op_t          mem_op;
    logic [1:0]   offset;
    logic [7:0]   byte_sel;
    logic [15:0]  half_sel;

    // older slot owns the port if it touches memory
    assign mem_op = is_mem_op(slot1.op) ? slot1.op : slot0.op;
    assign offset = is_mem_op(slot1.op) ? slot1.mem_addr[1:0] : slot0.mem_addr[1:0];

    // little endian lanes
    assign byte_sel = rdata[{offset, 3'b000} +: 8];
    assign half_sel = offset[1] ? rdata[31:16] : rdata[15:0];

    always_comb
    begin
        case (mem_op)
            OP_LB:   load_data = {{24{byte_sel[7]}}, byte_sel};
            OP_LBU:  load_data = {24'd0, byte_sel};
            OP_LH:   load_data = {{16{half_sel[15]}}, half_sel};
            OP_LHU:  load_data = {16'd0, half_sel};
            default: load_data = rdata;
        endcase
    end

endmodule

/* src/redirect_unit.sv */
`timescale 1ns/100ps

module redirect_unit
    import commit_pkg::*;
(
    slot_if.dst   slot1,
    output logic  redirect_valid,
    output logic  bpb_wen,
    output logic  bpb_taken,
    output word_t redirect_pc,
    output word_t bpb_pc,
    output word_t bpb_target
);

    logic branch_miss;
    logic jump_miss;
    logic taken_eff;

    assign branch_miss = slot1.is_branch && (slot1.taken != slot1.pred_taken);
    assign jump_miss   = slot1.is_jump && !slot1.pred_taken;

    // a jump always goes to its target
    assign taken_eff = slot1.taken || slot1.is_jump;

    assign redirect_valid = slot1.valid && (branch_miss || jump_miss);
    assign redirect_pc    = taken_eff ? slot1.target : slot1.pc + PAIR_BYTES;

    assign bpb_wen    = slot1.valid && (slot1.is_branch || slot1.is_jump);
    assign bpb_pc     = slot1.pc;
    assign bpb_taken  = taken_eff;
    assign bpb_target = slot1.target;

endmodule

/* src/slot_if.sv */
`timescale 1ns/100ps

interface slot_if
    import commit_pkg::*;
();

    logic      valid;
    word_t     pc;
    op_t       op;
    reg_addr_t destreg;
    logic      regwrite;
    logic      memtoreg;
    word_t     alu_result;
    word_t     mem_addr;
    logic      is_branch;
    logic      is_jump;
    logic      taken;
    logic      pred_taken;
    word_t     target;

    modport src (
        output valid, pc, op, destreg, regwrite, memtoreg, alu_result,
        output mem_addr, is_branch, is_jump, taken, pred_taken, target
    );

    modport dst (
        input valid, pc, op, destreg, regwrite, memtoreg, alu_result,
        input mem_addr, is_branch, is_jump, taken, pred_taken, target
    );

endinterface

/* src/slot_writeback.sv */
`timescale 1ns/100ps

module slot_writeback
    import commit_pkg::*;
(
    slot_if.dst       slot,
    input  word_t     load_data,
    input  logic      finish,
    output logic      wb_en,
    output reg_addr_t wb_reg,
    output word_t     wb_data
);

    assign wb_data = slot.memtoreg ? load_data : slot.alu_result;
    assign wb_reg  = slot.destreg;

    // only write once the pair's memory access is done
    assign wb_en = slot.valid && slot.regwrite && finish;

endmodule

/* tb/commit_checker.sv */
`timescale 1ns/100ps

module commit_checker
    import commit_pkg::*;
(
    input logic      clk, rst_n, stall,
    input logic      valid_1, regwrite_1, memtoreg_1, is_branch_1, is_jump_1,
    input logic      taken_1, pred_taken_1,
    input word_t     pc_1, alu_result_1, mem_addr_1, target_1,
    input op_t       op_1,
    input reg_addr_t destreg_1,
    input logic      valid_0, regwrite_0, memtoreg_0,
    input word_t     alu_result_0, mem_addr_0,
    input op_t       op_0,
    input reg_addr_t destreg_0,
    input logic      dmem_en, dmem_data_ok,
    input word_t     dmem_rdata,
    input logic      wb_en_1, wb_en_0, finish, redirect_valid, bpb_wen, bpb_taken,
    input reg_addr_t wb_reg_1, wb_reg_0,
    input word_t     wb_data_1, wb_data_0, redirect_pc, bpb_pc, bpb_target
);

    int        errors = 0;
    logic      seen = 1'b0;
    logic      held_ok;
    word_t     held_data, pc, tgt;
    logic      br, jmp, tk, pr;
    logic [1:0] v;
    op_t       op [2];
    reg_addr_t rd [2];
    logic      rw [2], mr [2];
    word_t     alu [2], addr [2];

    task automatic check(input string name, input word_t exp, input word_t act);
        if (exp !== act)
        begin
            errors++;
            $display("FAILED %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // mirror of the commit register and the data_ok catch
    always @(posedge clk)
    begin
        seen <= 1'b1;
        v <= !rst_n ? 2'b00 : (stall ? v : {valid_1, valid_0});
        if (!stall)
        begin
            {pc, op[1], rd[1], rw[1], mr[1], alu[1], addr[1], br, jmp, tk, pr, tgt} <=
                {pc_1, op_1, destreg_1, regwrite_1, memtoreg_1, alu_result_1, mem_addr_1,
                 is_branch_1, is_jump_1, taken_1, pred_taken_1, target_1};
            {op[0], rd[0], rw[0], mr[0], alu[0], addr[0]} <=
                {op_0, destreg_0, regwrite_0, memtoreg_0, alu_result_0, mem_addr_0};
        end
        if (!rst_n || !stall)
        begin
            held_ok   <= 1'b0;
            held_data <= '0;
        end
        else if (dmem_data_ok && !held_ok)
        begin
            held_ok   <= 1'b1;
            held_data <= dmem_rdata;
        end
    end

    always @(negedge clk)
    begin
        logic  fin, te;
        word_t rd_now, sh, ld;
        int    s;
        if (seen)
        begin
            fin    = !dmem_en || dmem_data_ok || held_ok;
            rd_now = dmem_data_ok ? dmem_rdata : held_data;
            s      = (op[1] != OP_ALU) ? 1 : 0;
            sh     = rd_now >> (addr[s][1:0] * 8);
            case (op[s])
                OP_LB:   ld = {{24{sh[7]}}, sh[7:0]};
                OP_LBU:  ld = {24'd0, sh[7:0]};
                OP_LH:   ld = {{16{sh[15]}}, sh[15:0]};
                OP_LHU:  ld = {16'd0, sh[15:0]};
                default: ld = rd_now;
            endcase
            check("finish", word_t'(fin), word_t'(finish));
            check("wb_en_1", word_t'(v[1] && rw[1] && fin), word_t'(wb_en_1));
            check("wb_en_0", word_t'(v[0] && rw[0] && fin), word_t'(wb_en_0));
            if (wb_en_1)
            begin
                check("wb_reg_1", word_t'(rd[1]), word_t'(wb_reg_1));
                check("wb_data_1", mr[1] ? ld : alu[1], wb_data_1);
            end
            if (wb_en_0)
            begin
                check("wb_reg_0", word_t'(rd[0]), word_t'(wb_reg_0));
                check("wb_data_0", mr[0] ? ld : alu[0], wb_data_0);
            end
            te = tk || jmp;
            check("redirect_valid", word_t'(v[1] && ((br && tk != pr) || (jmp && !pr))),
                  word_t'(redirect_valid));
            if (redirect_valid)
                check("redirect_pc", te ? tgt : pc + 32'd8, redirect_pc);
            check("bpb_wen", word_t'(v[1] && (br || jmp)), word_t'(bpb_wen));
            if (bpb_wen)
            begin
                check("bpb_pc", pc, bpb_pc);
                check("bpb_taken", word_t'(te), word_t'(bpb_taken));
                check("bpb_target", tgt, bpb_target);
            end
        end
    end

endmodule

/* tb/commit_tb.sv */
`timescale 1ns/100ps

module commit_tb
    import commit_pkg::*;
;

    localparam int N = 22;

    logic      clk, rst_n, stall, ctl_stall;
    logic      valid_1, regwrite_1, memtoreg_1, is_branch_1, is_jump_1, taken_1, pred_taken_1;
    logic      valid_0, regwrite_0, memtoreg_0, is_branch_0, is_jump_0, taken_0, pred_taken_0;
    word_t     pc_1, alu_result_1, mem_addr_1, target_1, pc_0, alu_result_0, mem_addr_0;
    word_t     target_0, dmem_rdata, wb_data_1, wb_data_0, redirect_pc, bpb_pc, bpb_target;
    op_t       op_1, op_0;
    reg_addr_t destreg_1, destreg_0, wb_reg_1, wb_reg_0;
    logic      dmem_en, dmem_data_ok, wb_en_1, wb_en_0, finish;
    logic      redirect_valid, bpb_wen, bpb_taken;

    slot_bits_t t1 [N];
    slot_bits_t t0 [N];
    word_t      tword [N];
    logic       tmem [N];
    int         tdly [N], thold [N];
    int         n = 0;
    int         seed = 32'h9da4_8218;

    assign stall = !finish || ctl_stall;

    commit_top dut0 (.*);
    commit_checker chk0 (.*);

    function automatic slot_bits_t mk(word_t pc, op_t op, reg_addr_t rd, logic rw, word_t val,
                                      word_t addr, logic [3:0] bj);
        mk = {1'b1, pc, op, rd, rw, (op >= OP_LB && op <= OP_LW), val, addr, bj, val};
    endfunction

    function automatic slot_bits_t alu(word_t pc, reg_addr_t rd, logic rw, word_t val);
        alu = mk(pc, OP_ALU, rd, rw, val, '0, 4'b0000);
    endfunction

    function automatic slot_bits_t ld(word_t pc, op_t op, reg_addr_t rd, word_t addr);
        ld = mk(pc, op, rd, 1'b1, 32'hbad0_0000, addr, 4'b0000);
    endfunction

    // bj is {is_branch, is_jump, taken, pred_taken}
    function automatic slot_bits_t br(word_t pc, logic [3:0] bj, word_t tgt);
        br = mk(pc, OP_ALU, 5'd0, 1'b0, tgt, '0, bj);
    endfunction

    task automatic add(slot_bits_t s1, slot_bits_t s0, word_t w, logic m, int d, int h);
        t1[n] = s1;
        t0[n] = s0;
        tword[n] = w;
        tmem[n] = m;
        tdly[n] = d;
        thold[n] = h;
        n++;
    endtask

    task automatic drive_pair(input slot_bits_t s1, input slot_bits_t s0);
        {valid_1, pc_1, op_1, destreg_1, regwrite_1, memtoreg_1, alu_result_1, mem_addr_1,
         is_branch_1, is_jump_1, taken_1, pred_taken_1, target_1} = s1;
        {valid_0, pc_0, op_0, destreg_0, regwrite_0, memtoreg_0, alu_result_0, mem_addr_0,
         is_branch_0, is_jump_0, taken_0, pred_taken_0, target_0} = s0;
    endtask

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // worst entry needs about ten cycles
    initial
    begin
        #((N * 10 + 10) * 100);
        $display("timeout, the commit stage never finished the test table");
        $display("=== FAIL ===");
        $finish;
    end

    initial
    begin
        int jit;
        rst_n = 1'b0;
        ctl_stall = 1'b0;
        dmem_en = 1'b0;
        dmem_data_ok = 1'b0;
        dmem_rdata = '0;
        drive_pair('0, '0);
        add(alu(32'h100, 5'd1, 1, 32'h1111_0001), alu(32'h104, 5'd2, 1, 32'h2222_0002), 0, 0, 0, 0);
        add(alu(32'h108, 5'd3, 0, 32'h3), alu(32'h10c, 5'd4, 1, 32'h4444_0004), 0, 0, 0, 0);
        add(ld(32'h110, OP_LB, 5'd5, 32'h1000), alu(32'h114, 5'd6, 1, 32'h66), 32'h80f1_7f82, 1, 0, 0);
        add(ld(32'h118, OP_LB, 5'd7, 32'h1001), alu(32'h11c, 5'd8, 0, 32'h0), 32'h80f1_7f82, 1, 1, 0);
        add(ld(32'h120, OP_LBU, 5'd9, 32'h1002), alu(32'h124, 5'd8, 0, 0), 32'h80f1_7f82, 1, 0, 0);
        add(ld(32'h128, OP_LBU, 5'd10, 32'h1003), alu(32'h12c, 5'd8, 0, 0), 32'h80f1_7f82, 1, 0, 0);
        add(alu(32'h130, 5'd11, 1, 32'h11), ld(32'h134, OP_LH, 5'd12, 32'h2002), 32'h8001_f0f0, 1, 0, 0);
        add(ld(32'h138, OP_LHU, 5'd13, 32'h2002), alu(32'h13c, 5'd8, 0, 0), 32'h8001_f0f0, 1, 0, 0);
        add(ld(32'h140, OP_LH, 5'd14, 32'h2000), alu(32'h144, 5'd8, 0, 0), 32'h8001_f0f0, 1, 0, 0);
        add(ld(32'h148, OP_LW, 5'd15, 32'h3000), alu(32'h14c, 5'd16, 1, 32'h16), 32'hcafe_f00d, 1, 3, 0);
        add(ld(32'h150, OP_LW, 5'd17, 32'h3004), alu(32'h154, 5'd8, 0, 0), 32'h1234_5678, 1, 1, 2);
        add(mk(32'h158, OP_SW, 5'd0, 0, 32'h99, 32'h3008, 4'b0000), alu(32'h15c, 5'd18, 1, 32'h18),
            32'h0, 1, 0, 0);
        add(br(32'h160, 4'b1010, 32'h400), alu(32'h164, 5'd19, 1, 32'h19), 0, 0, 0, 0);
        add(br(32'h168, 4'b1001, 32'h500), alu(32'h16c, 5'd8, 0, 0), 0, 0, 0, 0);
        add(br(32'h170, 4'b0100, 32'h600), alu(32'h174, 5'd8, 0, 0), 0, 0, 0, 0);
        add(br(32'h178, 4'b1011, 32'h700), alu(32'h17c, 5'd8, 0, 0), 0, 0, 0, 0);
        add(br(32'h180, 4'b0101, 32'h800), alu(32'h184, 5'd8, 0, 0), 0, 0, 0, 0);
        add(ld(32'h188, OP_LB, 5'd20, 32'h1002), alu(32'h18c, 5'd8, 0, 0), 32'h80f1_7f82, 1, 0, 0);
        add(ld(32'h190, OP_LB, 5'd21, 32'h1003), alu(32'h194, 5'd8, 0, 0), 32'h80f1_7f82, 1, 0, 0);
        add(ld(32'h198, OP_LBU, 5'd22, 32'h1000), alu(32'h19c, 5'd8, 0, 0), 32'h80f1_7f82, 1, 0, 0);
        add(ld(32'h1a0, OP_LBU, 5'd23, 32'h1001), alu(32'h1a4, 5'd8, 0, 0), 32'h80f1_7f82, 1, 0, 0);
        add(ld(32'h1a8, OP_LHU, 5'd24, 32'h2000), alu(32'h1ac, 5'd8, 0, 0), 32'h8001_f0f0, 1, 0, 0);
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int i = 0; i < n; i++)
        begin
            drive_pair(t1[i], t0[i]);
            dmem_en = 1'b0;
            ctl_stall = 1'b0;
            @(posedge clk);
            #1 drive_pair('0, '0);
            if (tmem[i])
            begin
                // memory answers after table delay plus a little jitter
                jit = $unsigned($random(seed)) % 3;
                dmem_en = 1'b1;
                dmem_rdata = 32'hdead_beef;
                ctl_stall = (thold[i] != 0);
                repeat (tdly[i] + jit)
                begin
                    @(posedge clk);
                    #1;
                end
                dmem_data_ok = 1'b1;
                dmem_rdata = tword[i];
                @(posedge clk);
                #1 dmem_data_ok = 1'b0;
                dmem_rdata = ~tword[i];
                repeat (thold[i])
                begin
                    @(posedge clk);
                    #1;
                end
                ctl_stall = 1'b0;
            end
            else
            begin
                @(posedge clk);
                #1;
            end
        end
        dmem_en = 1'b0;
        repeat (2) @(posedge clk);
        $display("checks done, %0d errors", chk0.errors);
        if (chk0.errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule
